//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_rv_core
FILELIST = sim.f
OBJDIR   = obj_dir

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

//--- rv_config.svh
// sizes assume a word-addressed external memory; only full 32-bit accesses exist
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// data path and address width
`define RV_XLEN 32

// register index, 32 registers
`define RV_REG_ADDR_BITS 5

// external memory word address, 1024 words
`define RV_MEM_ADDR_BITS 10

// debugger, data access, fetch
`define RV_NUM_REQ 3

`endif

//--- rv_controller.sv
// one instruction at a time; start_i is only seen while paused, halt leaves pc on the halt word
`default_nettype none

`include "rv_config.svh"

module rv_controller (
    input  wire                             clk,
    input  wire                             rst_i,
    input  wire                             start_i,
    input  wire [`RV_XLEN - 1:0]            start_address_i,
    output logic                            paused_o,
    output rv_pkg::mem_req_t                fetch_req_o,
    input  wire                             fetch_gnt_i,
    output rv_pkg::mem_req_t                data_req_o,
    input  wire                             data_gnt_i,
    input  wire                             rvalid_fetch_i,
    input  wire                             rvalid_data_i,
    input  wire [`RV_XLEN - 1:0]            rdata_i,
    output logic [`RV_XLEN - 1:0]           ir_o,
    output logic [`RV_XLEN - 1:0]           pc_o,
    input  wire rv_pkg::decode_t            dec_i,
    input  wire [`RV_XLEN - 1:0]            result_i,
    input  wire [`RV_MEM_ADDR_BITS - 1:0]   mem_addr_i,
    input  wire                             branch_taken_i,
    input  wire [`RV_XLEN - 1:0]            branch_target_i,
    input  wire [`RV_XLEN - 1:0]            rs2_data_i,
    output logic                            rd_we_o,
    output logic [`RV_REG_ADDR_BITS - 1:0]  rd_addr_o,
    output logic [`RV_XLEN - 1:0]           rd_data_o
);

    localparam logic [`RV_XLEN - 1:0] PC_STEP = 4;

    typedef enum logic [2:0] {
        S_PAUSED,
        S_FETCH,
        S_FETCH_WAIT,
        S_EXEC,
        S_MEM,
        S_MEM_WAIT,
        S_WRITEBACK
    } state_e;

    state_e                 state_q;
    logic [`RV_XLEN - 1:0]  pc_q;
    logic [`RV_XLEN - 1:0]  ir_q;
    logic                   is_alu;
    logic                   is_mem;

    assign is_alu = (dec_i.op == rv_pkg::OP_LUI) || (dec_i.op == rv_pkg::OP_ADDI) ||
                    (dec_i.op == rv_pkg::OP_ADD) || (dec_i.op == rv_pkg::OP_SUB);
    assign is_mem = (dec_i.op == rv_pkg::OP_LW) || (dec_i.op == rv_pkg::OP_SW);

    // -------------------------------------
    // state machine and pc
    // -------------------------------------
    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= S_PAUSED;
            pc_q    <= '0;
        end else begin
            case (state_q)
                S_PAUSED: begin
                    if (start_i) begin
                        pc_q    <= start_address_i;
                        state_q <= S_FETCH;
                    end
                end
                S_FETCH: begin
                    if (fetch_gnt_i) state_q <= S_FETCH_WAIT;
                end
                S_FETCH_WAIT: begin
                    if (rvalid_fetch_i) state_q <= S_EXEC;
                end
                S_EXEC: begin
                    if (dec_i.op == rv_pkg::OP_HALT) begin
                        state_q <= S_PAUSED;
                    end else begin
                        pc_q    <= branch_taken_i ? branch_target_i : pc_q + PC_STEP;
                        state_q <= is_mem ? S_MEM : S_FETCH;
                    end
                end
                S_MEM: begin
                    if (data_gnt_i) begin
                        state_q <= (dec_i.op == rv_pkg::OP_LW) ? S_MEM_WAIT : S_WRITEBACK;
                    end
                end
                S_MEM_WAIT: begin
                    if (rvalid_data_i) state_q <= S_FETCH;
                end
                // store retires here, the write went out with the grant
                S_WRITEBACK: state_q <= S_FETCH;
                default:     state_q <= S_PAUSED;
            endcase
        end
    end

    // instruction register
    always_ff @(posedge clk) begin
        if (state_q == S_FETCH_WAIT && rvalid_fetch_i) begin
            ir_q <= rdata_i;
        end
    end

    assign paused_o = (state_q == S_PAUSED);
    assign ir_o     = ir_q;
    assign pc_o     = pc_q;

    // -------------------------------------
    // memory requests
    // -------------------------------------
    always_comb begin
        fetch_req_o       = '0;
        fetch_req_o.re    = (state_q == S_FETCH);
        fetch_req_o.addr  = pc_q[`RV_MEM_ADDR_BITS + 1:2];

        data_req_o        = '0;
        data_req_o.re     = (state_q == S_MEM) && (dec_i.op == rv_pkg::OP_LW);
        data_req_o.we     = (state_q == S_MEM) && (dec_i.op == rv_pkg::OP_SW);
        data_req_o.addr   = mem_addr_i;
        data_req_o.wdata  = rs2_data_i;
    end

    // writeback, alu result in exec, load data when it returns
    assign rd_we_o   = ((state_q == S_EXEC) && is_alu) ||
                       ((state_q == S_MEM_WAIT) && rvalid_data_i);
    assign rd_addr_o = dec_i.rd;
    assign rd_data_o = (state_q == S_MEM_WAIT) ? rdata_i : result_i;

endmodule

`default_nettype wire

//--- rv_core_properties.sv
// arbiter checks only; they are held off while rst_i is high
`default_nettype none

`include "rv_config.svh"

module rv_core_properties (
    input  wire                                      clk,
    input  wire                                      rst_i,
    input  wire rv_pkg::mem_req_t [`RV_NUM_REQ-1:0]  req_i,
    input  wire [`RV_NUM_REQ - 1:0]                  gnt_i,
    input  wire [`RV_NUM_REQ - 1:0]                  rvalid_i
);

    logic [`RV_NUM_REQ - 1:0] active;
    logic [`RV_NUM_REQ - 1:0] rd_active;

    always_comb begin
        for (int i = 0; i < `RV_NUM_REQ; i++) begin
            active[i]    = req_i[i].re || req_i[i].we;
            rd_active[i] = req_i[i].re;
        end
    end

    // -------------------------------------
    // grant rules
    // -------------------------------------
    a_one_grant: assert property (@(posedge clk) disable iff (rst_i) $onehot0(gnt_i))
        else $error("arbiter gave more than one grant");

    a_grant_has_req: assert property (@(posedge clk) disable iff (rst_i)
        (gnt_i & ~active) == '0)
        else $error("arbiter granted a port without a request");

    // response goes to the read owner of the previous cycle only
    a_rvalid_after_read: assert property (@(posedge clk) disable iff (rst_i)
        rvalid_i == $past(gnt_i & rd_active))
        else $error("rvalid does not follow a read grant by one cycle");

endmodule

bind rv_mem_arbiter rv_core_properties i_properties (
    .clk      (clk),
    .rst_i    (rst_i),
    .req_i    (req_i),
    .gnt_i    (gnt_o),
    .rvalid_i (rvalid_o)
);

`default_nettype wire

//--- rv_core_top.sv
// external memory must return read data one cycle after the request and never stall
`default_nettype none

`include "rv_config.svh"

module rv_core_top (
    input  wire                             clk,
    input  wire                             rst_i,
    input  wire                             start_i,
    input  wire [`RV_XLEN - 1:0]            start_address_i,
    output logic                            paused_o,
    input  wire rv_pkg::mem_req_t           dbg_mem_req_i,
    output logic                            dbg_gnt_o,
    output logic                            dbg_rvalid_o,
    output logic [`RV_XLEN - 1:0]           dbg_rdata_o,
    input  wire [`RV_REG_ADDR_BITS - 1:0]   dbg_reg_addr_i,
    input  wire                             dbg_reg_we_i,
    input  wire [`RV_XLEN - 1:0]            dbg_reg_wdata_i,
    output logic [`RV_XLEN - 1:0]           dbg_reg_rdata_o,
    output rv_pkg::mem_req_t                mem_req_o,
    input  wire [`RV_XLEN - 1:0]            mem_rdata_i
);

    rv_pkg::mem_req_t                fetch_req;
    rv_pkg::mem_req_t                data_req;
    logic                            fetch_gnt;
    logic                            data_gnt;
    logic                            fetch_rvalid;
    logic                            data_rvalid;
    logic [`RV_XLEN - 1:0]           ir;
    logic [`RV_XLEN - 1:0]           pc;
    rv_pkg::decode_t                 dec;
    logic [`RV_XLEN - 1:0]           rs1_data;
    logic [`RV_XLEN - 1:0]           result;
    logic [`RV_MEM_ADDR_BITS - 1:0]  mem_addr;
    logic                            branch_taken;
    logic [`RV_XLEN - 1:0]           branch_target;
    logic                            rd_we;
    logic [`RV_REG_ADDR_BITS - 1:0]  rd_addr;
    logic [`RV_XLEN - 1:0]           rd_data;

    // -------------------------------------
    // memory arbiter, debugger first
    // -------------------------------------
    rv_mem_arbiter i_arbiter (
        .clk         (clk),
        .rst_i       (rst_i),
        .req_i       ({fetch_req, data_req, dbg_mem_req_i}),
        .gnt_o       ({fetch_gnt, data_gnt, dbg_gnt_o}),
        .rvalid_o    ({fetch_rvalid, data_rvalid, dbg_rvalid_o}),
        .rdata_o     (dbg_rdata_o),
        .mem_req_o   (mem_req_o),
        .mem_rdata_i (mem_rdata_i)
    );

    // rs2 port doubles as the debugger read port while paused
    rv_reg_file i_reg_file (
        .clk             (clk),
        .rst_i           (rst_i),
        .paused_i        (paused_o),
        .rs1_addr_i      (dec.rs1),
        .rs2_addr_i      (dec.rs2),
        .rs1_data_o      (rs1_data),
        .rs2_data_o      (dbg_reg_rdata_o),
        .we_i            (rd_we),
        .waddr_i         (rd_addr),
        .wdata_i         (rd_data),
        .dbg_reg_addr_i  (dbg_reg_addr_i),
        .dbg_reg_we_i    (dbg_reg_we_i),
        .dbg_reg_wdata_i (dbg_reg_wdata_i)
    );

    rv_decode i_decode (
        .ir_i  (ir),
        .dec_o (dec)
    );

    rv_execute i_execute (
        .dec_i           (dec),
        .pc_i            (pc),
        .rs1_data_i      (rs1_data),
        .rs2_data_i      (dbg_reg_rdata_o),
        .result_o        (result),
        .mem_addr_o      (mem_addr),
        .branch_taken_o  (branch_taken),
        .branch_target_o (branch_target)
    );

    rv_controller i_controller (
        .clk             (clk),
        .rst_i           (rst_i),
        .start_i         (start_i),
        .start_address_i (start_address_i),
        .paused_o        (paused_o),
        .fetch_req_o     (fetch_req),
        .fetch_gnt_i     (fetch_gnt),
        .data_req_o      (data_req),
        .data_gnt_i      (data_gnt),
        .rvalid_fetch_i  (fetch_rvalid),
        .rvalid_data_i   (data_rvalid),
        .rdata_i         (dbg_rdata_o),
        .ir_o            (ir),
        .pc_o            (pc),
        .dec_i           (dec),
        .result_i        (result),
        .mem_addr_i      (mem_addr),
        .branch_taken_i  (branch_taken),
        .branch_target_i (branch_target),
        .rs2_data_i      (dbg_reg_rdata_o),
        .rd_we_o         (rd_we),
        .rd_addr_o       (rd_addr),
        .rd_data_o       (rd_data)
    );

endmodule

`default_nettype wire

//--- rv_decode.sv
// only LUI, ADDI, ADD, SUB, LW, SW, BEQ, BNE are recognised; every other word decodes as halt
`default_nettype none

`include "rv_config.svh"

module rv_decode (
    input  wire [`RV_XLEN - 1:0]  ir_i,
    output rv_pkg::decode_t       dec_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    assign opcode = ir_i[6:0];
    assign funct3 = ir_i[14:12];
    assign funct7 = ir_i[31:25];

    always_comb begin
        dec_o.rd  = ir_i[11:7];
        dec_o.rs1 = ir_i[19:15];
        dec_o.rs2 = ir_i[24:20];
        dec_o.op  = rv_pkg::OP_HALT;
        // I-type immediate unless the class says otherwise
        dec_o.imm = {{20{ir_i[31]}}, ir_i[31:20]};

        case (opcode)
            7'b0110111: begin
                dec_o.op  = rv_pkg::OP_LUI;
                dec_o.imm = {ir_i[31:12], 12'b0};
            end
            7'b0010011: begin
                if (funct3 == 3'b000) dec_o.op = rv_pkg::OP_ADDI;
            end
            7'b0110011: begin
                if (funct3 == 3'b000 && funct7 == 7'b0000000) begin
                    dec_o.op = rv_pkg::OP_ADD;
                end else if (funct3 == 3'b000 && funct7 == 7'b0100000) begin
                    dec_o.op = rv_pkg::OP_SUB;
                end
            end
            7'b0000011: begin
                if (funct3 == 3'b010) dec_o.op = rv_pkg::OP_LW;
            end
            7'b0100011: begin
                if (funct3 == 3'b010) dec_o.op = rv_pkg::OP_SW;
                dec_o.imm = {{20{ir_i[31]}}, ir_i[31:25], ir_i[11:7]};
            end
            7'b1100011: begin
                if (funct3 == 3'b000) begin
                    dec_o.op = rv_pkg::OP_BEQ;
                end else if (funct3 == 3'b001) begin
                    dec_o.op = rv_pkg::OP_BNE;
                end
                // B-type, bit 0 always zero
                dec_o.imm = {{20{ir_i[31]}}, ir_i[7], ir_i[30:25], ir_i[11:8], 1'b0};
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

//--- rv_execute.sv
// purely combinational; load/store address bits 1:0 are dropped, no alignment check
`default_nettype none

`include "rv_config.svh"

module rv_execute (
    input  wire rv_pkg::decode_t           dec_i,
    input  wire [`RV_XLEN - 1:0]           pc_i,
    input  wire [`RV_XLEN - 1:0]           rs1_data_i,
    input  wire [`RV_XLEN - 1:0]           rs2_data_i,
    output logic [`RV_XLEN - 1:0]          result_o,
    output logic [`RV_MEM_ADDR_BITS - 1:0] mem_addr_o,
    output logic                           branch_taken_o,
    output logic [`RV_XLEN - 1:0]          branch_target_o
);

    logic [`RV_XLEN - 1:0] byte_addr;
    logic                  equal;

    // alu
    always_comb begin
        case (dec_i.op)
            rv_pkg::OP_LUI:  result_o = dec_i.imm;
            rv_pkg::OP_ADDI: result_o = rs1_data_i + dec_i.imm;
            rv_pkg::OP_ADD:  result_o = rs1_data_i + rs2_data_i;
            rv_pkg::OP_SUB:  result_o = rs1_data_i - rs2_data_i;
            default:         result_o = '0;
        endcase
    end

    // word address into the external memory
    assign byte_addr  = rs1_data_i + dec_i.imm;
    assign mem_addr_o = byte_addr[`RV_MEM_ADDR_BITS + 1:2];

    // branch compare and target
    assign equal           = (rs1_data_i == rs2_data_i);
    assign branch_taken_o  = ((dec_i.op == rv_pkg::OP_BEQ) && equal) ||
                             ((dec_i.op == rv_pkg::OP_BNE) && !equal);
    assign branch_target_o = pc_i + dec_i.imm;

endmodule

`default_nettype wire

//--- rv_mem_arbiter.sv
// fixed priority, index 0 highest; memory must answer reads in exactly one cycle
`default_nettype none

`include "rv_config.svh"

module rv_mem_arbiter (
    input  wire                                      clk,
    input  wire                                      rst_i,
    input  wire rv_pkg::mem_req_t [`RV_NUM_REQ-1:0]  req_i,
    output logic [`RV_NUM_REQ - 1:0]                 gnt_o,
    output logic [`RV_NUM_REQ - 1:0]                 rvalid_o,
    output logic [`RV_XLEN - 1:0]                    rdata_o,
    output rv_pkg::mem_req_t                         mem_req_o,
    input  wire [`RV_XLEN - 1:0]                     mem_rdata_i
);

    logic [`RV_NUM_REQ - 1:0] rd_gnt;
    logic [`RV_NUM_REQ - 1:0] rd_owner_q;

    // -------------------------------------
    // grant selection
    // -------------------------------------
    // walk from lowest priority up so the highest active request wins
    always_comb begin
        gnt_o     = '0;
        mem_req_o = '0;
        rd_gnt    = '0;
        for (int i = `RV_NUM_REQ - 1; i >= 0; i--) begin
            if (req_i[i].re || req_i[i].we) begin
                gnt_o     = '0;
                gnt_o[i]  = 1'b1;
                rd_gnt    = '0;
                rd_gnt[i] = req_i[i].re;
                mem_req_o = req_i[i];
            end
        end
    end

    // -------------------------------------
    // read response routing
    // -------------------------------------
    // remember who owns the data coming back next cycle
    always_ff @(posedge clk) begin
        if (rst_i) begin
            rd_owner_q <= '0;
        end else begin
            rd_owner_q <= rd_gnt;
        end
    end

    assign rvalid_o = rd_owner_q;

    // data is shared, only the rvalid bit tells who it belongs to
    assign rdata_o = mem_rdata_i;

endmodule

`default_nettype wire

//--- rv_pkg.sv
// shared types only; word addresses on the memory bus, byte addresses inside the core
`default_nettype none

`include "rv_config.svh"

package rv_pkg;

    // -------------------------------------
    // memory request
    // -------------------------------------
    // re and we are never set together by any requester
    typedef struct packed {
        logic                            re;
        logic                            we;
        logic [`RV_MEM_ADDR_BITS - 1:0]  addr;
        logic [`RV_XLEN - 1:0]           wdata;
    } mem_req_t;

    // -------------------------------------
    // decoded instruction
    // -------------------------------------
    typedef enum logic [3:0] {
        OP_LUI,
        OP_ADDI,
        OP_ADD,
        OP_SUB,
        OP_LW,
        OP_SW,
        OP_BEQ,
        OP_BNE,
        OP_HALT
    } op_e;

    // imm already sign-extended, or shifted for lui
    typedef struct packed {
        op_e                             op;
        logic [`RV_REG_ADDR_BITS - 1:0]  rd;
        logic [`RV_REG_ADDR_BITS - 1:0]  rs1;
        logic [`RV_REG_ADDR_BITS - 1:0]  rs2;
        logic [`RV_XLEN - 1:0]           imm;
    } decode_t;

endpackage

`default_nettype wire

//--- rv_reg_file.sv
// x0 reads zero; debugger port takes read port 2 and the write port only while paused
`default_nettype none

`include "rv_config.svh"

module rv_reg_file (
    input  wire                               clk,
    input  wire                               rst_i,
    input  wire                               paused_i,
    input  wire [`RV_REG_ADDR_BITS - 1:0]     rs1_addr_i,
    input  wire [`RV_REG_ADDR_BITS - 1:0]     rs2_addr_i,
    output logic [`RV_XLEN - 1:0]             rs1_data_o,
    output logic [`RV_XLEN - 1:0]             rs2_data_o,
    input  wire                               we_i,
    input  wire [`RV_REG_ADDR_BITS - 1:0]     waddr_i,
    input  wire [`RV_XLEN - 1:0]              wdata_i,
    input  wire [`RV_REG_ADDR_BITS - 1:0]     dbg_reg_addr_i,
    input  wire                               dbg_reg_we_i,
    input  wire [`RV_XLEN - 1:0]              dbg_reg_wdata_i
);

    localparam int NUM_REGS = 1 << `RV_REG_ADDR_BITS;

    logic [`RV_XLEN - 1:0]            regs_q [NUM_REGS];
    logic [`RV_REG_ADDR_BITS - 1:0]   rd2_addr;
    logic                             wr_en;
    logic [`RV_REG_ADDR_BITS - 1:0]   wr_addr;
    logic [`RV_XLEN - 1:0]            wr_data;

    // port sharing with the debugger
    assign rd2_addr = paused_i ? dbg_reg_addr_i  : rs2_addr_i;
    assign wr_en    = paused_i ? dbg_reg_we_i    : we_i;
    assign wr_addr  = paused_i ? dbg_reg_addr_i  : waddr_i;
    assign wr_data  = paused_i ? dbg_reg_wdata_i : wdata_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (wr_en && (wr_addr != '0)) begin
            regs_q[wr_addr] <= wr_data;
        end
    end

    // x0 is cleared by reset and never written
    assign rs1_data_o = regs_q[rs1_addr_i];
    assign rs2_data_o = regs_q[rd2_addr];

endmodule

`default_nettype wire

//--- sim.f
+incdir+.
rv_pkg.sv
rv_mem_arbiter.sv
rv_reg_file.sv
rv_decode.sv
rv_execute.sv
rv_controller.sv
rv_core_top.sv
rv_core_properties.sv
tb_rv_core.sv

//--- tb_rv_core.sv
// one random program run from address 0; memory model answers every read one cycle later
`default_nettype none

`include "rv_config.svh"

module tb_rv_core;

    localparam int PROG_LEN   = 40;
    localparam int DATA_BASE  = 512;
    localparam int DATA_WORDS = 64;
    localparam int MEM_WORDS  = 1 << `RV_MEM_ADDR_BITS;
    localparam int TIMEOUT    = 4000;

    // instruction classes of the generated program
    localparam int K_LUI  = 0;
    localparam int K_ADDI = 1;
    localparam int K_ADD  = 2;
    localparam int K_SUB  = 3;
    localparam int K_LW   = 4;
    localparam int K_SW   = 5;
    localparam int K_BEQ  = 6;
    localparam int K_BNE  = 7;
    localparam int K_HALT = 8;

    logic                            clk = 1'b0;
    logic                            rst_i;
    logic                            start_i;
    logic [`RV_XLEN - 1:0]           start_address_i;
    logic                            paused_o;
    rv_pkg::mem_req_t                dbg_mem_req_i;
    logic                            dbg_gnt_o;
    logic                            dbg_rvalid_o;
    logic [`RV_XLEN - 1:0]           dbg_rdata_o;
    logic [`RV_REG_ADDR_BITS - 1:0]  dbg_reg_addr_i;
    logic                            dbg_reg_we_i;
    logic [`RV_XLEN - 1:0]           dbg_reg_wdata_i;
    logic [`RV_XLEN - 1:0]           dbg_reg_rdata_o;
    rv_pkg::mem_req_t                mem_req_o;
    logic [`RV_XLEN - 1:0]           mem_rdata_i = '0;

    logic [31:0] mem [MEM_WORDS];
    logic [31:0] model_mem [MEM_WORDS];
    logic [31:0] model_regs [32];
    logic [31:0] lcg_state = 32'h4bf9;

    int          prog_kind [PROG_LEN + 1];
    logic [4:0]  prog_rd [PROG_LEN + 1];
    logic [4:0]  prog_rs1 [PROG_LEN + 1];
    logic [4:0]  prog_rs2 [PROG_LEN + 1];
    logic [31:0] prog_imm [PROG_LEN + 1];
    logic [31:0] prog_word [PROG_LEN + 1];

    always #4 clk = ~clk;

    rv_core_top i_dut (
        .clk             (clk),
        .rst_i           (rst_i),
        .start_i         (start_i),
        .start_address_i (start_address_i),
        .paused_o        (paused_o),
        .dbg_mem_req_i   (dbg_mem_req_i),
        .dbg_gnt_o       (dbg_gnt_o),
        .dbg_rvalid_o    (dbg_rvalid_o),
        .dbg_rdata_o     (dbg_rdata_o),
        .dbg_reg_addr_i  (dbg_reg_addr_i),
        .dbg_reg_we_i    (dbg_reg_we_i),
        .dbg_reg_wdata_i (dbg_reg_wdata_i),
        .dbg_reg_rdata_o (dbg_reg_rdata_o),
        .mem_req_o       (mem_req_o),
        .mem_rdata_i     (mem_rdata_i)
    );

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    function automatic logic [31:0] fill_word(input logic [9:0] addr);
        return {6'h2b, addr, 6'h14, ~addr};
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = lcg_next();
        return int'(r[30:8]) % n;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic check_equal(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error at time %0t: %s, expected %h, got %h",
                     $time, what, expected, actual);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timed out while waiting for %s", what);
        $display("TESTS FAILED");
        $fatal(1, "wait limit reached");
    endtask

    // external memory, pattern fill on reset, one cycle read latency
    always @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < MEM_WORDS; i++) begin
                mem[i] <= fill_word(10'(i));
            end
            mem_rdata_i <= '0;
        end else begin
            if (mem_req_o.we) begin
                mem[mem_req_o.addr] <= mem_req_o.wdata;
            end
            mem_rdata_i <= mem[mem_req_o.addr];
        end
    end

    // starts at posedge + 1 and returns there
    task automatic dbg_mem_access(input logic wr, input logic [9:0] addr,
                                  input logic [31:0] wdata, output logic [31:0] rdata);
        int cnt;
        rdata                = '0;
        dbg_mem_req_i.re     = !wr;
        dbg_mem_req_i.we     = wr;
        dbg_mem_req_i.addr   = addr;
        dbg_mem_req_i.wdata  = wdata;
        cnt = 0;
        @(negedge clk);
        while (!dbg_gnt_o) begin
            cnt++;
            if (cnt >= TIMEOUT) begin
                report_timeout("debugger memory grant");
            end
            @(negedge clk);
        end
        next_cycle();
        dbg_mem_req_i = '0;
        if (!wr) begin
            cnt = 0;
            @(negedge clk);
            while (!dbg_rvalid_o) begin
                cnt++;
                if (cnt >= TIMEOUT) begin
                    report_timeout("debugger read data");
                end
                @(negedge clk);
            end
            rdata = dbg_rdata_o;
            next_cycle();
        end
    endtask

    // ----------------------------------------
    // random program and ISA model
    // ----------------------------------------
    task automatic gen_program();
        int          kind;
        int          tgt;
        logic [31:0] r;
        logic [11:0] off12;
        logic [12:0] boff;
        logic [2:0]  f3;
        logic [31:0] imm;
        logic [31:0] word;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        for (int i = 0; i < PROG_LEN; i++) begin
            kind = rand_below(8);
            rd   = 5'(1 + rand_below(7));
            rs1  = 5'(rand_below(8));
            rs2  = 5'(rand_below(8));
            r    = lcg_next();
            imm  = '0;
            // x0 base with negative offset, word address wraps into 512..575
            off12 = 12'h800 | {4'b0, r[5:0], 2'b00};
            case (kind)
                K_LUI: begin
                    imm  = {r[31:12], 12'b0};
                    word = {r[31:12], rd, 7'b0110111};
                end
                K_ADDI: begin
                    imm  = {{20{r[11]}}, r[11:0]};
                    word = {r[11:0], rs1, 3'b000, rd, 7'b0010011};
                end
                K_ADD: begin
                    word = {7'b0000000, rs2, rs1, 3'b000, rd, 7'b0110011};
                end
                K_SUB: begin
                    word = {7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011};
                end
                K_LW: begin
                    rs1  = '0;
                    imm  = {{20{off12[11]}}, off12};
                    word = {off12, 5'd0, 3'b010, rd, 7'b0000011};
                end
                K_SW: begin
                    rs1  = '0;
                    imm  = {{20{off12[11]}}, off12};
                    word = {off12[11:5], rs2, 5'd0, 3'b010, off12[4:0], 7'b0100011};
                end
                default: begin
                    // forward only, at most up to the halt word
                    tgt  = i + 1 + rand_below(PROG_LEN - i);
                    boff = 13'((tgt - i) * 4);
                    imm  = {19'b0, boff};
                    f3   = (kind == K_BNE) ? 3'b001 : 3'b000;
                    word = {boff[12], boff[10:5], rs2, rs1, f3, boff[4:1], boff[11], 7'b1100011};
                end
            endcase
            prog_kind[i] = kind;
            prog_rd[i]   = rd;
            prog_rs1[i]  = rs1;
            prog_rs2[i]  = rs2;
            prog_imm[i]  = imm;
            prog_word[i] = word;
        end
        prog_kind[PROG_LEN] = K_HALT;
        prog_rd[PROG_LEN]   = '0;
        prog_rs1[PROG_LEN]  = '0;
        prog_rs2[PROG_LEN]  = '0;
        prog_imm[PROG_LEN]  = '0;
        prog_word[PROG_LEN] = '0;
    endtask

    task automatic run_model();
        int          pc;
        int          next_pc;
        logic [31:0] s1;
        logic [31:0] s2;
        logic [31:0] a;
        for (int w = 0; w < MEM_WORDS; w++) begin
            model_mem[w] = fill_word(10'(w));
        end
        for (int i = 0; i <= PROG_LEN; i++) begin
            model_mem[i] = prog_word[i];
        end
        for (int x = 0; x < 32; x++) begin
            model_regs[x] = '0;
        end
        pc = 0;
        while (prog_kind[pc] != K_HALT) begin
            s1      = model_regs[prog_rs1[pc]];
            s2      = model_regs[prog_rs2[pc]];
            a       = s1 + prog_imm[pc];
            next_pc = pc + 1;
            case (prog_kind[pc])
                K_LUI:  model_regs[prog_rd[pc]] = prog_imm[pc];
                K_ADDI: model_regs[prog_rd[pc]] = a;
                K_ADD:  model_regs[prog_rd[pc]] = s1 + s2;
                K_SUB:  model_regs[prog_rd[pc]] = s1 - s2;
                K_LW:   model_regs[prog_rd[pc]] = model_mem[a[11:2]];
                K_SW:   model_mem[a[11:2]] = s2;
                K_BEQ: begin
                    if (s1 == s2) begin
                        next_pc = pc + int'(prog_imm[pc] >> 2);
                    end
                end
                default: begin
                    if (s1 != s2) begin
                        next_pc = pc + int'(prog_imm[pc] >> 2);
                    end
                end
            endcase
            pc = next_pc;
        end
    endtask

    // ----------------------------------------
    // main sequence
    // ----------------------------------------
    initial begin
        logic [31:0] rdata;
        logic [31:0] wval;
        int          cnt;
        rst_i           = 1'b1;
        start_i         = 1'b0;
        start_address_i = '0;
        dbg_mem_req_i   = '0;
        dbg_reg_addr_i  = '0;
        dbg_reg_we_i    = 1'b0;
        dbg_reg_wdata_i = '0;
        repeat (2) begin
            next_cycle();
        end
        rst_i = 1'b0;

        @(negedge clk);
        check_equal("paused_o after reset", 32'd1, {31'b0, paused_o});
        check_equal("mem re after reset", 32'd0, {31'b0, mem_req_o.re});
        check_equal("mem we after reset", 32'd0, {31'b0, mem_req_o.we});
        next_cycle();

        gen_program();
        run_model();
        for (int i = 0; i <= PROG_LEN; i++) begin
            dbg_mem_access(1'b1, 10'(i), prog_word[i], rdata);
        end
        for (int i = 0; i <= PROG_LEN; i++) begin
            dbg_mem_access(1'b0, 10'(i), '0, rdata);
            check_equal($sformatf("program word %0d", i), prog_word[i], rdata);
        end

        start_i         = 1'b1;
        start_address_i = '0;
        next_cycle();
        start_i = 1'b0;
        @(negedge clk);
        check_equal("paused_o after start", 32'd0, {31'b0, paused_o});
        cnt = 0;
        while (!paused_o) begin
            cnt++;
            if (cnt >= TIMEOUT) begin
                report_timeout("program halt");
            end
            @(negedge clk);
        end
        next_cycle();

        for (int r = 0; r < 32; r++) begin
            dbg_reg_addr_i = 5'(r);
            @(negedge clk);
            check_equal($sformatf("register x%0d", r), model_regs[r], dbg_reg_rdata_o);
            next_cycle();
        end
        for (int w = DATA_BASE; w < DATA_BASE + DATA_WORDS; w++) begin
            dbg_mem_access(1'b0, 10'(w), '0, rdata);
            check_equal($sformatf("data word %0d", w), model_mem[w], rdata);
        end

        // debugger register writes, x0 must stay zero
        wval            = lcg_next();
        dbg_reg_we_i    = 1'b1;
        dbg_reg_addr_i  = 5'd0;
        dbg_reg_wdata_i = 32'hffff_ffff;
        next_cycle();
        dbg_reg_addr_i  = 5'd5;
        dbg_reg_wdata_i = wval;
        next_cycle();
        dbg_reg_we_i    = 1'b0;
        dbg_reg_addr_i  = 5'd0;
        @(negedge clk);
        check_equal("x0 after debugger write", 32'd0, dbg_reg_rdata_o);
        next_cycle();
        dbg_reg_addr_i = 5'd5;
        @(negedge clk);
        check_equal("x5 after debugger write", wval, dbg_reg_rdata_o);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire
